/* motorPwmPkg.sv */
package motorPwmPkg;

    // one command per commutation window
    typedef struct packed {
        logic [3:0]  step;
        logic [11:0] pulseLen;
    } pwmCmdT;

    // bridge leg that carries the pulse during a step
    typedef enum logic [1:0] {
        phaseA    = 2'd0,
        phaseB    = 2'd1,
        phaseC    = 2'd2,
        phaseNone = 2'd3
    } phaseSelT;

    // timing strobes and window fields, registered in the decode stage
    typedef struct packed {
        // a command was taken for this window
        logic        windowActive;
        logic        periodStart;
        logic        windowFirst;
        logic        windowLast;
        phaseSelT    phase;
        logic [3:0]  step;
        logic [11:0] pulseLen;
    } periodCtrlT;

    // end of window summary
    typedef struct packed {
        logic [3:0]  step;
        // stepPeriods times the requested length
        logic [15:0] wantCount;
        // high cycles actually driven on the phase
        logic [15:0] realCount;
        // carry left over plus clipped excess
        logic [15:0] lostCount;
    } windowReportT;

endpackage

/* commutationDecoder.sv */
`timescale 1ns/1ns

module commutationDecoder import motorPwmPkg::*; #(
    parameter int periodLen   = 64,
    parameter int stepPeriods = 4,
    parameter int cmdDepth    = 2
) (
    input  logic       clk,
    input  logic       arstN,
    input  logic       cmdValid,
    input  pwmCmdT     cmd,
    output logic       creditReturn,
    output periodCtrlT ctrl
);

    localparam int cntW  = (periodLen > 1) ? $clog2(periodLen) : 1;
    localparam int idxW  = (stepPeriods > 1) ? $clog2(stepPeriods) : 1;
    localparam int ptrW  = (cmdDepth > 1) ? $clog2(cmdDepth) : 1;
    localparam int fillW = $clog2(cmdDepth + 1);

    pwmCmdT          queueMem [cmdDepth];
    logic [ptrW-1:0] wrPtr;
    logic [ptrW-1:0] rdPtr;
    logic [fillW-1:0] fillCount;

    logic [cntW-1:0] periodCnt;
    logic [idxW-1:0] periodIdx;
    logic            periodBegin;
    logic            windowStart;
    logic            windowEnd;
    logic            popCmd;
    pwmCmdT          headCmd;

    // steps come in groups of four per leg, the top group is unused
    function automatic phaseSelT stepToPhase(input logic [3:0] step);
        case (step[3:2])
            2'd0:    return phaseA;
            2'd1:    return phaseB;
            2'd2:    return phaseC;
            default: return phaseNone;
        endcase
    endfunction

    assign periodBegin = (periodCnt == '0);
    assign windowStart = periodBegin && (periodIdx == '0);
    assign windowEnd   = (periodCnt == cntW'(periodLen - 1))
                      && (periodIdx == idxW'(stepPeriods - 1));
    // no bypass, the command must already sit in the queue
    assign popCmd      = windowStart && (fillCount != '0);
    assign headCmd     = queueMem[rdPtr];

    // queue storage
    always_ff @(posedge clk) begin
        if (cmdValid) begin
            queueMem[wrPtr] <= cmd;
        end
    end

    // queue pointers and fill level, credits keep it from overflowing
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            wrPtr     <= '0;
            rdPtr     <= '0;
            fillCount <= '0;
        end else begin
            if (cmdValid) begin
                wrPtr <= (wrPtr == ptrW'(cmdDepth - 1)) ? '0 : wrPtr + 1'b1;
            end
            if (popCmd) begin
                rdPtr <= (rdPtr == ptrW'(cmdDepth - 1)) ? '0 : rdPtr + 1'b1;
            end
            case ({cmdValid, popCmd})
                2'b10:   fillCount <= fillCount + 1'b1;
                2'b01:   fillCount <= fillCount - 1'b1;
                default: fillCount <= fillCount;
            endcase
        end
    end

    // free running period and window counters
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            periodCnt <= '0;
            periodIdx <= '0;
        end else if (periodCnt == cntW'(periodLen - 1)) begin
            periodCnt <= '0;
            periodIdx <= (periodIdx == idxW'(stepPeriods - 1)) ? '0 : periodIdx + 1'b1;
        end else begin
            periodCnt <= periodCnt + 1'b1;
        end
    end

    // strobes follow the counters by one cycle, window fields held for the window
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            ctrl         <= '0;
            creditReturn <= 1'b0;
        end else begin
            creditReturn     <= popCmd;
            ctrl.periodStart <= periodBegin;
            ctrl.windowFirst <= windowStart;
            ctrl.windowLast  <= windowEnd;
            if (windowStart) begin
                ctrl.windowActive <= popCmd;
                ctrl.step         <= popCmd ? headCmd.step : 4'd0;
                ctrl.pulseLen     <= popCmd ? headCmd.pulseLen : 12'd0;
                // idle window gets no leg at all
                ctrl.phase        <= popCmd ? stepToPhase(headCmd.step) : phaseNone;
            end
        end
    end

endmodule

/* pulseModulator.sv */
`timescale 1ns/1ns

module pulseModulator import motorPwmPkg::*; #(
    parameter int periodLen = 64,
    parameter int minPulse  = 16
) (
    input  logic       clk,
    input  logic       arstN,
    input  periodCtrlT ctrl,
    output logic       pulse
);

    localparam int cntW = (periodLen > 1) ? $clog2(periodLen) : 1;
    // longest pulse still leaves one low cycle per period
    localparam logic [15:0] clipLen = 16'(periodLen - 1);
    localparam logic [15:0] minLen  = 16'(minPulse);

    logic [15:0]     carry;
    logic [15:0]     lenSum;
    logic [15:0]     width;
    logic            belowMin;
    logic [cntW-1:0] highCnt;

    // skip, carry or clip decision for the coming period
    always_comb begin
        lenSum   = carry + 16'(ctrl.pulseLen);
        belowMin = (lenSum < minLen);
        if (!ctrl.windowActive || belowMin) begin
            width = 16'd0;
        end else if (lenSum > clipLen) begin
            width = clipLen;
        end else begin
            width = lenSum;
        end
    end

    // short requests roll into the next period, nothing crosses a window
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            carry <= 16'd0;
        end else if (ctrl.windowLast) begin
            carry <= 16'd0;
        end else if (ctrl.periodStart && ctrl.windowActive) begin
            carry <= belowMin ? lenSum : 16'd0;
        end
    end

    // high time counts down from the emitted width
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            highCnt <= '0;
        end else if (ctrl.periodStart) begin
            highCnt <= cntW'(width);
        end else if (highCnt != '0) begin
            highCnt <= highCnt - 1'b1;
        end
    end

    // high from the cycle after periodStart for width cycles
    assign pulse = (highCnt != '0);

endmodule

/* windowAccountant.sv */
`timescale 1ns/1ns

module windowAccountant import motorPwmPkg::*; (
    input  logic         clk,
    input  logic         arstN,
    input  periodCtrlT   ctrl,
    input  logic         pulse,
    output logic [2:0]   pwm,
    output logic         reportValid,
    output windowReportT report
);

    logic [15:0] wantAcc;
    logic [15:0] realAcc;
    logic [15:0] wantNext;
    logic [15:0] realNext;
    logic        driven;
    logic        reportNow;

    // one leg at a time, bit 0 is phase A
    always_comb begin
        pwm = 3'b000;
        case (ctrl.phase)
            phaseA:  pwm[0] = pulse;
            phaseB:  pwm[1] = pulse;
            phaseC:  pwm[2] = pulse;
            default: pwm = 3'b000;
        endcase
    end

    // only cycles that reach a leg count as real
    assign driven    = |pwm;
    assign wantNext  = wantAcc
                     + ((ctrl.windowActive && ctrl.periodStart) ? 16'(ctrl.pulseLen) : 16'd0);
    assign realNext  = realAcc + 16'(driven);
    assign reportNow = ctrl.windowLast && ctrl.windowActive;

    // window totals, restart after every window end
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            wantAcc <= 16'd0;
            realAcc <= 16'd0;
        end else if (ctrl.windowLast) begin
            wantAcc <= 16'd0;
            realAcc <= 16'd0;
        end else begin
            wantAcc <= wantNext;
            realAcc <= realNext;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            reportValid <= 1'b0;
        end else begin
            reportValid <= reportNow;
        end
    end

    // windowLast cycle is folded in through the next values
    always_ff @(posedge clk) begin
        if (reportNow) begin
            report.step      <= ctrl.step;
            report.wantCount <= wantNext;
            report.realCount <= realNext;
            report.lostCount <= wantNext - realNext;
        end
    end

endmodule

/* motorPwmCore.sv */
`timescale 1ns/1ns

module motorPwmCore import motorPwmPkg::*; #(
    parameter int periodLen   = 64,
    parameter int stepPeriods = 4,
    parameter int minPulse    = 16,
    parameter int cmdDepth    = 2
) (
    input  logic         clk,
    input  logic         arstN,
    input  logic         cmdValid,
    input  pwmCmdT       cmd,
    output logic         creditReturn,
    output logic [2:0]   pwm,
    output logic         reportValid,
    output windowReportT report
);

    periodCtrlT ctrl;
    logic       pulse;

    // decode: queue, credits and window timing
    commutationDecoder #(
        .periodLen   (periodLen),
        .stepPeriods (stepPeriods),
        .cmdDepth    (cmdDepth)
    ) decodeStage (
        .clk          (clk),
        .arstN        (arstN),
        .cmdValid     (cmdValid),
        .cmd          (cmd),
        .creditReturn (creditReturn),
        .ctrl         (ctrl)
    );

    // execute: carry, minimum and clip
    pulseModulator #(
        .periodLen (periodLen),
        .minPulse  (minPulse)
    ) executeStage (
        .clk   (clk),
        .arstN (arstN),
        .ctrl  (ctrl),
        .pulse (pulse)
    );

    // result: phase routing and window report
    windowAccountant resultStage (
        .clk         (clk),
        .arstN       (arstN),
        .ctrl        (ctrl),
        .pulse       (pulse),
        .pwm         (pwm),
        .reportValid (reportValid),
        .report      (report)
    );

endmodule

/* motorPwmCore_props.sv */
`timescale 1ns/1ns

module motorPwmCore_props import motorPwmPkg::*; #(
    parameter int cmdDepth = 2
) (
    input logic                           clk,
    input logic                           arstN,
    input logic [2:0]                     pwm,
    input logic                           creditReturn,
    input logic [$clog2(cmdDepth+1)-1:0] fillCount,
    input logic                           reportValid,
    input windowReportT                   report
);

    // property failures seen so far
    int failCount = 0;

    // never two bridge legs at once
    phaseExclusive: assert property (@(posedge clk) disable iff (!arstN)
        $onehot0(pwm))
    else begin
        failCount++;
        $error("more than one pwm leg high in the same cycle");
    end

    // credit comes back one cycle after a pop, so the queue held a command then
    creditFromQueue: assert property (@(posedge clk) disable iff (!arstN)
        creditReturn |-> ($past(fillCount) != 0))
    else begin
        failCount++;
        $error("creditReturn without a queued command");
    end

    queueBound: assert property (@(posedge clk) disable iff (!arstN)
        fillCount <= cmdDepth)
    else begin
        failCount++;
        $error("command queue holds more than cmdDepth entries");
    end

    reportBalance: assert property (@(posedge clk) disable iff (!arstN)
        reportValid |-> (report.lostCount == report.wantCount - report.realCount))
    else begin
        failCount++;
        $error("report lost count does not match want minus real");
    end

endmodule

// queue fill level is taken straight from the decode stage
bind motorPwmCore motorPwmCore_props #(.cmdDepth(cmdDepth)) propsCheck (
    .clk          (clk),
    .arstN        (arstN),
    .pwm          (pwm),
    .creditReturn (creditReturn),
    .fillCount    (decodeStage.fillCount),
    .reportValid  (reportValid),
    .report       (report)
);

/* motorPwmTb.sv */
`timescale 1ns/1ns

module motorPwmTb import motorPwmPkg::*; ();

    localparam int periodLen     = 64;
    localparam int stepPeriods   = 4;
    localparam int minPulse      = 16;
    localparam int cmdDepth      = 2;
    localparam int windowCycles  = periodLen * stepPeriods;
    localparam int waitLimit     = (cmdDepth + 3) * windowCycles;
    localparam int directedCount = 8;
    localparam int randomCount   = 24;
    // the queue is allowed to run dry before this command
    localparam int idleAfter     = 16;

    logic         clk;
    logic         arstN;
    logic         cmdValid;
    pwmCmdT       cmd;
    logic         creditReturn;
    logic [2:0]   pwm;
    logic         reportValid;
    windowReportT report;

    // sent but not yet taken, and taken but not yet reported
    pwmCmdT       expectQ[$];
    pwmCmdT       flightQ[$];
    int           sentCount;
    int           returnedCount;
    int           reportCount;
    int           highCycles;
    // cycles since reset release, a window starts at every multiple of windowCycles
    int           cycleCount;
    logic         monitorOn;
    logic [31:0]  rngState;
    pwmCmdT       doneCmd;
    windowReportT expRep;

    motorPwmCore #(
        .periodLen   (periodLen),
        .stepPeriods (stepPeriods),
        .minPulse    (minPulse),
        .cmdDepth    (cmdDepth)
    ) UUT (
        .clk          (clk),
        .arstN        (arstN),
        .cmdValid     (cmdValid),
        .cmd          (cmd),
        .creditReturn (creditReturn),
        .pwm          (pwm),
        .reportValid  (reportValid),
        .report       (report)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic failNow(input string msg);
        $display("%s", msg);
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic checkReport(input windowReportT got, input windowReportT exp);
        if (got !== exp) begin
            failNow($sformatf({"Fail report: got step %h want %h real %h lost %h,",
                               " expected step %h want %h real %h lost %h"},
                              got.step, got.wantCount, got.realCount, got.lostCount,
                              exp.step, exp.wantCount, exp.realCount, exp.lostCount));
        end
    endtask

    task automatic checkPhase(input phaseSelT got, input phaseSelT exp);
        if (got !== exp) begin
            failNow($sformatf("Fail pwm phase: got %h expected %h", got, exp));
        end
    endtask

    task automatic checkCredit(input string name, input int got, input int exp);
        if (got != exp) begin
            failNow($sformatf("Fail %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic checkCount(input string name, input int got, input int exp);
        if (got != exp) begin
            failNow($sformatf("Fail %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic checkLevel(input string name, input logic [2:0] got, input logic [2:0] exp);
        if (got !== exp) begin
            failNow($sformatf("Fail %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic expectQuiet();
        checkLevel("pwm", pwm, 3'b000);
        checkLevel("creditReturn", 3'(creditReturn), 3'b000);
        checkLevel("reportValid", 3'(reportValid), 3'b000);
    endtask

    function automatic logic [31:0] lcgNext(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // four steps per leg, last group drives nothing
    function automatic phaseSelT expectPhase(input logic [3:0] step);
        if (step < 4'd4) begin
            return phaseA;
        end else if (step < 4'd8) begin
            return phaseB;
        end else if (step < 4'd12) begin
            return phaseC;
        end
        return phaseNone;
    endfunction

    function automatic phaseSelT phaseFromPwm(input logic [2:0] legs);
        case (legs)
            3'b001:  return phaseA;
            3'b010:  return phaseB;
            3'b100:  return phaseC;
            default: return phaseNone;
        endcase
    endfunction

    // expected window summary from the carry, minimum and clip rules
    function automatic windowReportT refReport(input pwmCmdT c, input int pLen,
                                               input int nPeriods, input int minLen);
        windowReportT r;
        int           carry;
        int           sum;
        int           width;
        int           realSum;
        carry   = 0;
        realSum = 0;
        for (int p = 0; p < nPeriods; p++) begin
            sum = carry + int'(c.pulseLen);
            if (sum < minLen) begin
                carry = sum;
                width = 0;
            end else begin
                width = (sum > pLen - 1) ? pLen - 1 : sum;
                carry = 0;
            end
            realSum += width;
        end
        if (c.step >= 4'd12) begin
            realSum = 0;
        end
        r.step      = c.step;
        r.wantCount = 16'(nPeriods * int'(c.pulseLen));
        r.realCount = 16'(realSum);
        r.lostCount = r.wantCount - r.realCount;
        return r;
    endfunction

    // edge cases: zero, carried, exact minimum, full period, clipped
    function automatic pwmCmdT directedCmd(input int idx);
        case (idx)
            0:       return '{4'd0, 12'd0};
            1:       return '{4'd1, 12'd5};
            2:       return '{4'd5, 12'd15};
            3:       return '{4'd9, 12'd16};
            4:       return '{4'd13, 12'd40};
            5:       return '{4'd3, 12'd63};
            6:       return '{4'd7, 12'd64};
            default: return '{4'd11, 12'd4095};
        endcase
    endfunction

    // about half the lengths land below minPulse
    task automatic makeRandomCmd(output pwmCmdT c);
        rngState = lcgNext(rngState);
        c.step = rngState[27:24];
        case (rngState[31:30])
            2'd0, 2'd1: c.pulseLen = 12'(rngState[23:16] % minPulse);
            2'd2:       c.pulseLen = 12'(minPulse + rngState[23:16] % periodLen);
            default:    c.pulseLen = 12'(periodLen + rngState[23:12] % 1024);
        endcase
    endtask

    task automatic sendCommand(input pwmCmdT c);
        int waited;
        waited = 0;
        @(posedge clk);
        while (sentCount - returnedCount >= cmdDepth) begin
            if (waited >= waitLimit) begin
                failNow("timeout while waiting for a credit to come back");
            end
            waited++;
            @(posedge clk);
        end
        cmdValid <= 1'b1;
        cmd      <= c;
        expectQ.push_back(c);
        sentCount++;
        @(posedge clk);
        cmdValid <= 1'b0;
    endtask

    task automatic waitDrained();
        int waited;
        waited = 0;
        while (reportCount != sentCount) begin
            if (waited >= waitLimit) begin
                failNow("timeout while waiting for the reports of all sent commands");
            end
            waited++;
            @(posedge clk);
        end
    endtask

    // compare process, sampled at the falling edge where outputs are settled
    always @(negedge clk) begin
        if (monitorOn) begin
            if (UUT.propsCheck.failCount != 0) begin
                failNow("a bound property on the core failed");
            end
            // a report and the next window start can share a cycle
            if (reportValid) begin
                checkCount("reportValid window offset", cycleCount % windowCycles, 1);
                if (flightQ.size() == 0) begin
                    failNow("a report appeared for a window that had no command");
                end
                doneCmd = flightQ.pop_front();
                expRep  = refReport(doneCmd, periodLen, stepPeriods, minPulse);
                checkReport(report, expRep);
                checkCount("pwm high cycles", highCycles, int'(expRep.realCount));
                reportCount++;
                highCycles = 0;
            end
            if (creditReturn) begin
                checkCredit("creditReturn window offset", cycleCount % windowCycles, 1);
                returnedCount++;
                if (expectQ.size() == 0) begin
                    failNow("creditReturn came while no command was outstanding");
                end
                flightQ.push_back(expectQ.pop_front());
                highCycles = 0;
            end
            if (pwm != 3'b000) begin
                if ($countones(pwm) > 1) begin
                    failNow("more than one phase was high in the same cycle");
                end
                if (flightQ.size() == 0) begin
                    failNow("a phase went high in a window without a command");
                end
                checkPhase(phaseFromPwm(pwm), expectPhase(flightQ[0].step));
                highCycles++;
            end
            cycleCount++;
        end
    end

    initial begin
        pwmCmdT nextCmd;
        arstN         = 1'b0;
        cmdValid      = 1'b0;
        cmd           = '0;
        monitorOn     = 1'b0;
        sentCount     = 0;
        returnedCount = 0;
        reportCount   = 0;
        highCycles    = 0;
        cycleCount    = 0;
        rngState      = 32'hcd331ba5;
        repeat (4) begin
            @(negedge clk);
            expectQuiet();
        end
        @(posedge clk);
        arstN     <= 1'b1;
        monitorOn = 1'b1;
        @(negedge clk);
        expectQuiet();
        for (int i = 0; i < directedCount + randomCount; i++) begin
            if (i == idleAfter) begin
                // empty queue for two windows
                waitDrained();
                repeat (2 * windowCycles) @(posedge clk);
            end
            if (i < directedCount) begin
                nextCmd = directedCmd(i);
            end else begin
                makeRandomCmd(nextCmd);
            end
            sendCommand(nextCmd);
        end
        waitDrained();
        $display("*** PASSED ***");
        $finish;
    end

endmodule

/* build.f */
motorPwmPkg.sv
commutationDecoder.sv
pulseModulator.sv
windowAccountant.sv
motorPwmCore.sv
motorPwmCore_props.sv
motorPwmTb.sv
